// ==== common/basic_op_pkg.sv ====
`default_nettype none

package basic_op_pkg;

	typedef logic signed [15:0] word16_t;
	typedef logic signed [31:0] word32_t;
	typedef logic signed [5:0]  shift_t;

	localparam word32_t MAX_32 = 32'sh7fff_ffff;
	localparam word32_t MIN_32 = 32'sh8000_0000;
	localparam word16_t MAX_16 = 16'sh7fff;
	localparam word16_t MIN_16 = 16'sh8000;

	////////////////////////////////////////////////////////////
	// 16-bit operators

	function automatic word16_t sat_16(word32_t x);
		if (x > 32'sd32767)
			return MAX_16;
		if (x < -32'sd32768)
			return MIN_16;
		return x[15:0];
	endfunction

	function automatic word16_t add(word16_t a, word16_t b);
		return sat_16(word32_t'(a) + word32_t'(b));
	endfunction

	function automatic word16_t sub(word16_t a, word16_t b);
		return sat_16(word32_t'(a) - word32_t'(b));
	endfunction

	// Q15 product, only -1 * -1 overflows
	function automatic word16_t mult(word16_t a, word16_t b);
		word32_t p;
		p = (word32_t'(a) * word32_t'(b)) >>> 15;
		return sat_16(p);
	endfunction

	function automatic word16_t extract_h(word32_t a);
		return a[31:16];
	endfunction

	////////////////////////////////////////////////////////////
	// 32-bit operators

	function automatic word32_t l_mult(word16_t a, word16_t b);
		word32_t p;
		p = word32_t'(a) * word32_t'(b);
		if (p == 32'sh4000_0000)
			return MAX_32;
		return p <<< 1;
	endfunction

	function automatic word32_t l_add(word32_t a, word32_t b);
		word32_t s;
		s = a + b;
		if ((a[31] == b[31]) && (s[31] != a[31]))
			return a[31] ? MIN_32 : MAX_32;
		return s;
	endfunction

	function automatic word32_t l_sub(word32_t a, word32_t b);
		word32_t s;
		s = a - b;
		if ((a[31] != b[31]) && (s[31] != a[31]))
			return a[31] ? MIN_32 : MAX_32;
		return s;
	endfunction

	// Negative count turns into a saturating left shift
	function automatic word32_t l_shr(word32_t a, shift_t n);
		word32_t r;
		r = a;
		if (n < 0) begin
			for (int i = 0; i < 32; i++) begin
				if (i < -n) begin
					if (r > 32'sh3fff_ffff)
						r = MAX_32;
					else if (r < 32'shc000_0000)
						r = MIN_32;
					else
						r = r <<< 1;
				end
			end
		end else if (n >= 6'sd31) begin
			r = a[31] ? -32'sd1 : 32'sd0;
		end else begin
			r = a >>> n;
		end
		return r;
	endfunction

endpackage

`default_nettype wire

// ==== common/g729_gain_pkg.sv ====
`default_nettype none

package g729_gain_pkg;

	typedef struct packed {
		basic_op_pkg::word16_t pitch;
		basic_op_pkg::word16_t code;
	} gain_pair_t;

	typedef struct packed {
		logic [2:0] cand1;
		logic [3:0] cand2;
	} cand_t;

	typedef logic [4:0] rom_addr_t;

	////////////////////////////////////////////////////////////
	// Table layout

	localparam rom_addr_t COEF_BASE   = 5'd0;
	// High word first, L_coef[0][1] then L_coef[1][1]
	localparam rom_addr_t L_COEF_BASE = 5'd4;
	localparam rom_addr_t THR1_BASE   = 5'd8;
	localparam rom_addr_t THR2_BASE   = 5'd12;

	localparam int NCAN1 = 4;
	localparam int NCAN2 = 8;

	localparam basic_op_pkg::word16_t INV_COEF = 16'shbd31;

	localparam basic_op_pkg::word16_t GAIN_TABLE [0:19] = '{
		// coef[0][0], coef[0][1], coef[1][0], coef[1][1]
		16'sd31881, 16'sd26416, 16'sd31548, 16'sd27816,
		// L_coef[0][1], L_coef[1][1]
		16'sh6730, 16'sh4880, 16'sh6ca8, 16'sh9fc0,
		// thr1, Q14
		16'sd10808, 16'sd12374, 16'sd19778, 16'sd32567,
		// thr2, Q15
		16'sd14087, 16'sd16188, 16'sd20274, 16'sd21321,
		16'sd23525, 16'sd25232, 16'sd27873, 16'sd30542
	};

	typedef enum logic [3:0] {
		S_IDLE,
		S_CFBG,
		S_LC11_HI,
		S_LC11_LO,
		S_SHL_CODE,
		S_SHL_X,
		S_LC01_HI,
		S_LC01_LO,
		S_C10,
		S_SHL_Y,
		S_THR1_RD,
		S_THR1_CMP,
		S_THR2_RD,
		S_THR2_CMP
	} presel_state_e;

endpackage

`default_nettype wire

// ==== logic/l_shift_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module l_shift_unit #(
	parameter int SHIFT_WIDTH = 32
) (
	input  wire logic                          clock,
	input  wire logic                          reset,
	input  wire logic                          start,
	input  wire logic signed [SHIFT_WIDTH-1:0] value,
	input  wire basic_op_pkg::shift_t          count,
	output logic signed [SHIFT_WIDTH-1:0]      result,
	output logic                               done
);

	localparam logic signed [SHIFT_WIDTH-1:0] SAT_MAX = {1'b0, {(SHIFT_WIDTH-1){1'b1}}};
	localparam logic signed [SHIFT_WIDTH-1:0] SAT_MIN = {1'b1, {(SHIFT_WIDTH-1){1'b0}}};
	localparam logic signed [SHIFT_WIDTH-1:0] HALF_MAX = SAT_MAX >>> 1;
	localparam logic signed [SHIFT_WIDTH-1:0] HALF_MIN = SAT_MIN >>> 1;

	logic                          busy;
	logic [5:0]                    remaining;
	logic [5:0]                    steps;
	logic signed [SHIFT_WIDTH-1:0] shift_in;
	logic signed [SHIFT_WIDTH-1:0] shifted;

	// Negative counts do no shifting
	assign steps = count[5] ? 6'd0 : $unsigned(count);
	assign shift_in = start ? value : result;

	// One place per step, saturated values are fixed points
	always_comb begin
		if (shift_in > HALF_MAX)
			shifted = SAT_MAX;
		else if (shift_in < HALF_MIN)
			shifted = SAT_MIN;
		else
			shifted = shift_in <<< 1;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			remaining <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				remaining <= (steps == 6'd0) ? 6'd0 : steps - 6'd1;
				busy <= (steps > 6'd1);
				done <= (steps <= 6'd1);
			end else if (busy) begin
				remaining <= remaining - 6'd1;
				if (remaining == 6'd1) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// First step is taken on the load edge
	always_ff @(posedge clock) begin
		if (start)
			result <= (steps == 6'd0) ? value : shifted;
		else if (busy)
			result <= shifted;
	end

	a_no_start_when_busy: assert property (@(posedge clock) disable iff (reset)
		start |-> !busy);

endmodule

`default_nettype wire

// ==== logic/gain_const_rom.sv ====
`timescale 1ns/100ps
`default_nettype none

module gain_const_rom (
	input  wire logic                      clock,
	input  wire g729_gain_pkg::rom_addr_t  addr,
	output basic_op_pkg::word16_t          data
);

	import g729_gain_pkg::*;

	localparam int TABLE_DEPTH = $size(GAIN_TABLE);

	// Registered read, unused addresses read as zero
	always_ff @(posedge clock) begin
		if (int'(addr) < TABLE_DEPTH)
			data <= GAIN_TABLE[addr];
		else
			data <= '0;
	end

endmodule

`default_nettype wire

// ==== gain_presel/gain_presel.sv ====
`timescale 1ns/100ps
`default_nettype none

module gain_presel (
	input  wire logic                       clock,
	input  wire logic                       reset,
	input  wire logic                       start,
	input  wire basic_op_pkg::word16_t      gcode0,
	input  wire g729_gain_pkg::gain_pair_t  best_gain,
	input  wire basic_op_pkg::word16_t      rom_data,
	input  wire logic                       shl_done,
	input  wire basic_op_pkg::word32_t      shl_result,
	output logic                            done,
	output g729_gain_pkg::cand_t            cand,
	output g729_gain_pkg::rom_addr_t        rom_addr,
	output logic                            shl_start,
	output basic_op_pkg::word32_t           shl_value,
	output basic_op_pkg::shift_t            shl_count
);

	import basic_op_pkg::*;
	import g729_gain_pkg::*;

	// (14+4+1)-16 and (15+4+1)-15
	localparam shift_t SFT_Y = 6'sd3;
	localparam shift_t SFT_X = 6'sd5;

	presel_state_e state;
	presel_state_e state_next;

	word16_t    gcode0_q;
	gain_pair_t gain_q;
	word16_t    coef_hi;
	word16_t    acc_h;
	word32_t    l_cfbg;
	word32_t    l_preg;
	word32_t    l_tmp_x;
	word32_t    l_tmp_y;
	logic [2:0] c1;
	logic [3:0] c2;
	logic       shl_pending;

	word32_t    l_coef;
	word32_t    scaled;
	word32_t    thr_ref;
	shift_t     thr_sft;
	word32_t    l_temp;
	logic       gcode_pos;
	logic       step;
	logic [2:0] c1_inc;
	logic [3:0] c2_inc;
	logic [2:0] lim1;
	logic [3:0] lim2;
	logic       c1_last;
	logic       c2_last;

	assign l_coef = {coef_hi, rom_data};
	assign scaled = l_mult(extract_h(shl_result), INV_COEF);
	assign gcode_pos = (gcode0_q > 16'sd0);

	////////////////////////////////////////////////////////////
	// Threshold walk

	assign thr_ref = (state == S_THR1_CMP) ? l_tmp_y : l_tmp_x;
	assign thr_sft = (state == S_THR1_CMP) ? SFT_Y : SFT_X;
	assign l_temp = l_sub(thr_ref, l_shr(l_mult(rom_data, gcode0_q), thr_sft));

	// Sense flips for gcode0 <= 0
	assign step = gcode_pos ? (l_temp > 32'sd0) : (l_temp < 32'sd0);

	// Non-positive search ends one entry early
	assign lim1 = gcode_pos ? 3'(NCAN1) : 3'(NCAN1 - 1);
	assign lim2 = gcode_pos ? 4'(NCAN2) : 4'(NCAN2 - 1);
	assign c1_inc = c1 + 3'd1;
	assign c2_inc = c2 + 4'd1;
	assign c1_last = (c1_inc == lim1);
	assign c2_last = (c2_inc == lim2);

	////////////////////////////////////////////////////////////
	// Sequencer
	//   x = (best_gain[1] - (coef00*best_gain[0] + coef11)*gcode0) * inv_coef
	//   y = (coef10*(L_coef01 term)*gcode0 - coef10*best_gain[0]) * inv_coef

	always_comb begin
		state_next = state;
		rom_addr = COEF_BASE;
		shl_start = 1'b0;
		shl_value = word32_t'(gain_q.code);
		shl_count = 6'sd7;
		case (state)
			S_IDLE: begin
				if (start)
					state_next = S_CFBG;
			end
			S_CFBG: begin
				rom_addr = L_COEF_BASE + 5'd2;
				state_next = S_LC11_HI;
			end
			S_LC11_HI: begin
				rom_addr = L_COEF_BASE + 5'd3;
				state_next = S_LC11_LO;
			end
			S_LC11_LO: begin
				// Code gain Q1 -> Q8
				shl_start = 1'b1;
				state_next = S_SHL_CODE;
			end
			S_SHL_CODE: begin
				if (shl_done) begin
					shl_start = 1'b1;
					shl_value = l_sub(shl_result, l_preg);
					shl_count = 6'sd2;
					state_next = S_SHL_X;
				end
			end
			S_SHL_X: begin
				rom_addr = L_COEF_BASE;
				if (shl_done)
					state_next = S_LC01_HI;
			end
			S_LC01_HI: begin
				rom_addr = L_COEF_BASE + 5'd1;
				state_next = S_LC01_LO;
			end
			S_LC01_LO: begin
				rom_addr = COEF_BASE + 5'd2;
				state_next = S_C10;
			end
			S_C10: begin
				shl_start = 1'b1;
				shl_value = l_sub(l_mult(acc_h, rom_data),
					l_shr(l_mult(rom_data, gain_q.pitch), 6'sd3));
				shl_count = 6'sd2;
				state_next = S_SHL_Y;
			end
			S_SHL_Y: begin
				if (shl_done)
					state_next = S_THR1_RD;
			end
			S_THR1_RD: begin
				rom_addr = THR1_BASE + rom_addr_t'(c1);
				state_next = S_THR1_CMP;
			end
			S_THR1_CMP: begin
				state_next = (step && !c1_last) ? S_THR1_RD : S_THR2_RD;
			end
			S_THR2_RD: begin
				rom_addr = THR2_BASE + rom_addr_t'(c2);
				state_next = S_THR2_CMP;
			end
			S_THR2_CMP: begin
				state_next = (step && !c2_last) ? S_THR2_RD : S_IDLE;
			end
			default: state_next = S_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= S_IDLE;
			done <= 1'b0;
			cand <= '0;
			c1 <= '0;
			c2 <= '0;
		end else begin
			state <= state_next;
			done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start) begin
						c1 <= '0;
						c2 <= '0;
					end
				end
				S_THR1_CMP: begin
					if (step)
						c1 <= c1_inc;
				end
				S_THR2_CMP: begin
					if (step)
						c2 <= c2_inc;
					if (state_next == S_IDLE) begin
						done <= 1'b1;
						cand.cand1 <= c1;
						cand.cand2 <= step ? c2_inc : c2;
					end
				end
				default: ;
			endcase
		end
	end

	// Datapath registers
	always_ff @(posedge clock) begin
		case (state)
			S_IDLE: begin
				if (start) begin
					gcode0_q <= gcode0;
					gain_q <= best_gain;
				end
			end
			S_CFBG: l_cfbg <= l_mult(rom_data, gain_q.pitch);
			S_LC11_HI, S_LC01_HI: coef_hi <= rom_data;
			S_LC11_LO: begin
				l_preg <= l_mult(extract_h(l_add(l_cfbg, l_shr(l_coef, 6'sd15))),
					gcode0_q);
			end
			S_SHL_X: begin
				if (shl_done)
					l_tmp_x <= scaled;
			end
			S_LC01_LO: begin
				acc_h <= mult(extract_h(l_sub(l_cfbg, l_shr(l_coef, 6'sd10))), gcode0_q);
			end
			S_SHL_Y: begin
				if (shl_done)
					l_tmp_y <= scaled;
			end
			default: ;
		endcase
	end

	// Tracks a shift in flight across the shifter boundary
	always_ff @(posedge clock) begin
		if (reset)
			shl_pending <= 1'b0;
		else if (shl_start)
			shl_pending <= 1'b1;
		else if (shl_done)
			shl_pending <= 1'b0;
	end

	a_done_single: assert property (@(posedge clock) disable iff (reset)
		done |=> !done);

	a_cand_range: assert property (@(posedge clock) disable iff (reset)
		(cand.cand1 <= 3'(NCAN1)) && (cand.cand2 <= 4'(NCAN2)));

	a_one_shift: assert property (@(posedge clock) disable iff (reset)
		shl_start |-> (!shl_pending || shl_done));

endmodule

`default_nettype wire

// ==== logic/gain_presel_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module gain_presel_top #(
	parameter int SHIFT_WIDTH = 32
) (
	input  wire logic                       clock,
	input  wire logic                       reset,
	input  wire logic                       start,
	input  wire basic_op_pkg::word16_t      gcode0,
	input  wire g729_gain_pkg::gain_pair_t  best_gain,
	output logic                            done,
	output g729_gain_pkg::cand_t            cand
);

	import basic_op_pkg::*;
	import g729_gain_pkg::*;

	rom_addr_t rom_addr;
	word16_t   rom_data;
	logic      shl_start;
	logic      shl_done;
	word32_t   shl_value;
	word32_t   shl_result;
	shift_t    shl_count;

	gain_presel presel_i (
		.clock      (clock),
		.reset      (reset),
		.start      (start),
		.gcode0     (gcode0),
		.best_gain  (best_gain),
		.rom_data   (rom_data),
		.shl_done   (shl_done),
		.shl_result (shl_result),
		.done       (done),
		.cand       (cand),
		.rom_addr   (rom_addr),
		.shl_start  (shl_start),
		.shl_value  (shl_value),
		.shl_count  (shl_count)
	);

	gain_const_rom rom_i (
		.clock (clock),
		.addr  (rom_addr),
		.data  (rom_data)
	);

	l_shift_unit #(
		.SHIFT_WIDTH (SHIFT_WIDTH)
	) shl_i (
		.clock  (clock),
		.reset  (reset),
		.start  (shl_start),
		.value  (shl_value),
		.count  (shl_count),
		.result (shl_result),
		.done   (shl_done)
	);

endmodule

`default_nettype wire

// ==== dv/gain_presel_model.svh ====
`ifndef GAIN_PRESEL_MODEL_SVH
`define GAIN_PRESEL_MODEL_SVH

// Reference preselection for one vector
function automatic cand_t presel_model(word16_t g0, gain_pair_t bg);
	word16_t coef00;
	word16_t coef10;
	word16_t acc_h;
	word32_t l_coef11;
	word32_t l_coef01;
	word32_t l_cfbg;
	word32_t l_preg;
	word32_t l_tmp_x;
	word32_t l_tmp_y;
	word32_t l_temp;
	logic    pos;
	logic    stepping;
	int      lim1;
	int      lim2;
	int      c1;
	int      c2;
	cand_t   res;

	coef00 = GAIN_TABLE[COEF_BASE];
	coef10 = GAIN_TABLE[COEF_BASE + 5'd2];
	l_coef11 = {GAIN_TABLE[L_COEF_BASE + 5'd2], GAIN_TABLE[L_COEF_BASE + 5'd3]};
	l_coef01 = {GAIN_TABLE[L_COEF_BASE], GAIN_TABLE[L_COEF_BASE + 5'd1]};
	l_cfbg = l_mult(coef00, bg.pitch);

	// Code side, Q1 -> Q8, times 2^2, then into the threshold domain
	l_preg = l_mult(extract_h(l_add(l_cfbg, l_shr(l_coef11, 6'sd15))), g0);
	l_tmp_x = l_sub(l_shr(word32_t'(bg.code), -6'sd7), l_preg);
	l_tmp_x = l_mult(extract_h(l_shr(l_tmp_x, -6'sd2)), INV_COEF);

	// Pitch side
	acc_h = mult(extract_h(l_sub(l_cfbg, l_shr(l_coef01, 6'sd10))), g0);
	l_tmp_y = l_sub(l_mult(acc_h, coef10), l_shr(l_mult(coef10, bg.pitch), 6'sd3));
	l_tmp_y = l_mult(extract_h(l_shr(l_tmp_y, -6'sd2)), INV_COEF);

	pos = (g0 > 16'sd0);
	lim1 = pos ? NCAN1 : NCAN1 - 1;
	lim2 = pos ? NCAN2 : NCAN2 - 1;

	c1 = 0;
	stepping = 1'b1;
	while (stepping && (c1 < lim1)) begin
		l_temp = l_sub(l_tmp_y, l_shr(l_mult(GAIN_TABLE[THR1_BASE + c1], g0), 6'sd3));
		stepping = pos ? (l_temp > 0) : (l_temp < 0);
		if (stepping)
			c1++;
	end

	c2 = 0;
	stepping = 1'b1;
	while (stepping && (c2 < lim2)) begin
		l_temp = l_sub(l_tmp_x, l_shr(l_mult(GAIN_TABLE[THR2_BASE + c2], g0), 6'sd5));
		stepping = pos ? (l_temp > 0) : (l_temp < 0);
		if (stepping)
			c2++;
	end

	res.cand1 = 3'(c1);
	res.cand2 = 4'(c2);
	return res;
endfunction

`endif

// ==== dv/gain_presel_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module gain_presel_tb;

	import basic_op_pkg::*;
	import g729_gain_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int LFSR_ROWS = 30;
	localparam int EXTRA_RUNS = 2;
	localparam int IDLE_GAP = 3;

	typedef struct packed {
		word16_t    gcode0;
		gain_pair_t gain;
	} vector_t;

	logic       clock;
	logic       reset;
	logic       start;
	word16_t    gcode0;
	gain_pair_t best_gain;
	logic       done;
	cand_t      cand;

	string       row_name[$];
	vector_t     row_vec[$];
	cand_t       row_exp[$];
	int          row_lat[$];
	logic [15:0] lfsr_state;
	int          cycle_count = 0;
	int          cycle_limit = 1000000;
	cand_t       cand_seen;

	`include "gain_presel_model.svh"

	gain_presel_top #(
		.SHIFT_WIDTH (32)
	) dut_i (
		.clock     (clock),
		.reset     (reset),
		.start     (start),
		.gcode0    (gcode0),
		.best_gain (best_gain),
		.done      (done),
		.cand      (cand)
	);

	always #5 clock = ~clock;

	////////////////////////////////////////////////////////////
	// Failure handling and checks

	task automatic abort_run();
		$display("STATUS: FAIL");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
			abort_run();
		end
	endtask

	// Watchdog
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: no result after %0d clock cycles", cycle_count);
			abort_run();
		end
	end

	// cand may only move together with done
	always @(posedge clock) begin
		if (!reset && (cand !== cand_seen) && !done) begin
			$display("Candidates changed in a cycle without done");
			abort_run();
		end
		cand_seen = cand;
	end

	////////////////////////////////////////////////////////////
	// Vector table

	// Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [15:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[14:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic void add_row(string name, word16_t g0, word16_t pitch, word16_t code);
		vector_t v;
		v.gcode0 = g0;
		v.gain.pitch = pitch;
		v.gain.code = code;
		row_name.push_back(name);
		row_vec.push_back(v);
		row_exp.push_back(presel_model(g0, v.gain));
		row_lat.push_back(0);
	endfunction

	function automatic void load_fixed_rows();
		add_row("pos_mid_a", 16'sd2500, 16'sd8192, 16'sd1200);
		add_row("pos_mid_b", 16'sd1200, 16'sd11000, 16'sd3000);
		add_row("pos_mid_c", 16'sd6000, 16'sd4000, 16'sd500);
		add_row("pos_small", 16'sd1, 16'sd9830, 16'sd40);
		add_row("zero_g0", 16'sd0, 16'sd8192, 16'sd1200);
		add_row("neg_mid_a", -16'sd2500, 16'sd8192, 16'sd1200);
		add_row("neg_mid_b", -16'sd400, 16'sd12000, -16'sd800);
		add_row("sat_pos_max", 16'sd4000, 16'sd32767, 16'sd32767);
		add_row("sat_pos_min", 16'sd4000, -16'sd32768, -16'sd32768);
		add_row("sat_neg_max", -16'sd4000, 16'sd32767, 16'sd32767);
		add_row("sat_neg_min", -16'sd4000, -16'sd32768, -16'sd32768);
		add_row("sat_g0_max", 16'sd32767, 16'sd32767, -16'sd32768);
		add_row("sat_g0_min", -16'sd32768, -16'sd32768, 16'sd32767);
	endfunction

	////////////////////////////////////////////////////////////
	// One run with an optional second start pulse mid-run

	task automatic run_row(input int idx, input bit interfere, output int latency);
		vector_t v;
		vector_t other;
		string   name;
		logic    seen_done;
		v = row_vec[idx];
		other = row_vec[(idx + 5) % row_vec.size()];
		name = interfere ? {row_name[idx], " restart"} : row_name[idx];
		@(posedge clock);
		start <= 1'b1;
		gcode0 <= v.gcode0;
		best_gain <= v.gain;
		@(posedge clock);
		start <= 1'b0;
		latency = 0;
		seen_done = 1'b0;
		while (!seen_done) begin
			@(posedge clock);
			latency++;
			if (interfere && (latency == 4)) begin
				start <= 1'b1;
				gcode0 <= other.gcode0;
				best_gain <= other.gain;
			end else if (interfere && (latency == 5)) begin
				start <= 1'b0;
				gcode0 <= v.gcode0;
				best_gain <= v.gain;
			end
			seen_done = done;
		end
		check_value({name, " cand1 in range"}, 1, int'(cand.cand1 <= 3'(NCAN1)));
		check_value({name, " cand2 in range"}, 1, int'(cand.cand2 <= 4'(NCAN2)));
		check_value({name, " cand1"}, int'(row_exp[idx].cand1), int'(cand.cand1));
		check_value({name, " cand2"}, int'(row_exp[idx].cand2), int'(cand.cand2));
		repeat (IDLE_GAP) begin
			@(posedge clock);
			check_value({name, " done after pulse"}, 0, int'(done));
			check_value({name, " cand held"}, int'(row_exp[idx]), int'(cand));
		end
	endtask

	initial begin
		logic [15:0] bits_g;
		logic [15:0] bits_p;
		logic [15:0] bits_c;
		int          lat;
		clock = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		gcode0 = '0;
		best_gain = '0;
		lfsr_state = 16'd10487;

		load_fixed_rows();
		for (int i = 0; i < LFSR_ROWS; i++) begin
			take_bits(16, bits_g);
			take_bits(16, bits_p);
			take_bits(16, bits_c);
			add_row($sformatf("lfsr_%0d", i), bits_g, bits_p, bits_c);
		end
		cycle_limit = (row_vec.size() + EXTRA_RUNS) * 64 + RESET_CYCLES;

		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		check_value("after reset done", 0, int'(done));
		check_value("after reset cand", 0, int'(cand));

		for (int i = 0; i < row_vec.size(); i++) begin
			run_row(i, 1'b0, lat);
			row_lat[i] = lat;
		end

		// A start during a run is dropped and the next run is taken
		run_row(0, 1'b1, lat);
		check_value("restart latency", row_lat[0], lat);
		run_row(1, 1'b0, lat);

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+dv
common/basic_op_pkg.sv
common/g729_gain_pkg.sv
logic/l_shift_unit.sv
logic/gain_const_rom.sv
gain_presel/gain_presel.sv
logic/gain_presel_top.sv
dv/gain_presel_tb.sv

// ==== Makefile ====
BIN  = obj_dir/Vgain_presel_tb
SRCS = $(filter-out +incdir+%,$(shell cat list.f)) dv/gain_presel_model.svh

.PHONY: all run clean

all: run

$(BIN): list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module gain_presel_tb

run: $(BIN)
	./$(BIN) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" sim.log; then echo "Simulation gave no result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
